/* src/pc_periph_defs.svh */
//////////////////////////////////////////////////////////////////////
// Bus widths, I/O port addresses and EMS slot count
// for the chipset glue logic
//////////////////////////////////////////////////////////////////////

`ifndef PC_PERIPH_DEFS_SVH
`define PC_PERIPH_DEFS_SVH

// CPU bus
`define PC_ADDR_W       20
`define PC_DATA_W       8

// EMS page mapper
`define EMS_SLOTS       4
`define EMS_MAP_W       7
// First of four map registers, 0x260..0x263
`define EMS_PORT_BASE   16'h0260

// Keyboard scancode read port
`define KBD_PORT        16'h0060

// 32-port groups in the low I/O space
`define IO_GROUPS       8

`endif

/* src/pc_periph_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared vector types and the bus cycle and chip select structs
//////////////////////////////////////////////////////////////////////

`include "pc_periph_defs.svh"

package pc_periph_pkg;

    // Plain bus vectors
    typedef logic [`PC_ADDR_W-1:0] addr_t;
    typedef logic [`PC_DATA_W-1:0] data_t;

    // EMS mapper values
    typedef logic [`EMS_MAP_W-1:0]         ems_page_t;
    typedef logic [$clog2(`EMS_SLOTS)-1:0] ems_slot_t;

    // 0..3 picks window segment A000, C000, D000 or E000
    typedef logic [1:0] ems_base_sel_t;

    // One CPU bus cycle as seen by the chipset, 32 bits
    typedef struct packed {
        addr_t address;
        data_t write_data;
        logic  io_read_n;
        logic  io_write_n;
        logic  memory_read_n;
        logic  address_enable_n;
    } bus_cycle_t;

    // Decoded selects, 10 bits
    typedef struct packed {
        // Active low, one per 32-port group
        logic [`IO_GROUPS-1:0] group_sel_n;
        // EMS map register window hit
        logic                  ems_sel;
        // Scancode port hit
        logic                  kbd_sel;
    } chip_sel_t;

endpackage

/* src/io_decoder.sv */
//////////////////////////////////////////////////////////////////////
// Low I/O space decode into the 32-port group selects,
// plus the EMS register and scancode port selects
//////////////////////////////////////////////////////////////////////

`include "pc_periph_defs.svh"

module io_decoder (
    input  pc_periph_pkg::bus_cycle_t bus_i,
    input  logic                      ems_enabled_i,
    output pc_periph_pkg::chip_sel_t  sel_o
);

    logic       cpu_cycle;
    logic       low_io;
    logic [2:0] group_idx;
    logic       ems_port_hit;
    logic       kbd_port_hit;

    // DMA cycles raise address enable, so only CPU cycles decode
    assign cpu_cycle = ~bus_i.address_enable_n;

    // Ports 0x000..0x0FF
    assign low_io    = cpu_cycle & (bus_i.address[9:8] == 2'b00);
    assign group_idx = bus_i.address[7:5];

    // Map registers occupy four consecutive ports
    assign ems_port_hit = (bus_i.address[15:2] == (`EMS_PORT_BASE >> 2));
    assign kbd_port_hit = (bus_i.address[15:0] == `KBD_PORT);

    always_comb begin
        sel_o.group_sel_n = '1;
        if (low_io) begin
            sel_o.group_sel_n[group_idx] = 1'b0;
        end

        sel_o.ems_sel = ems_enabled_i & cpu_cycle & ems_port_hit;
        sel_o.kbd_sel = cpu_cycle & kbd_port_hit;
    end

endmodule

/* src/ems_mapper.sv */
//////////////////////////////////////////////////////////////////////
// EMS page map and enable registers, window hit outputs and
// map register read-back value
//////////////////////////////////////////////////////////////////////

`include "pc_periph_defs.svh"

module ems_mapper (
    input  logic                         clock,
    input  logic                         reset,
    input  pc_periph_pkg::bus_cycle_t    bus_i,
    input  pc_periph_pkg::chip_sel_t     sel_i,
    input  pc_periph_pkg::ems_base_sel_t ems_base_i,
    output logic [`EMS_SLOTS-1:0]        window_hit_o,
    output pc_periph_pkg::data_t         read_data_o
);

    pc_periph_pkg::ems_page_t map_q [`EMS_SLOTS];
    logic [`EMS_SLOTS-1:0]    ena_q;

    pc_periph_pkg::ems_slot_t slot;
    pc_periph_pkg::data_t     wdata;
    logic                     write_strobe;
    logic [3:0]               base_nibble;

    assign slot         = bus_i.address[1:0];
    assign wdata        = bus_i.write_data;
    assign write_strobe = sel_i.ems_sel & ~bus_i.io_write_n;

    // 0xFF unmaps the slot, 0x00..0x7F maps a page, the rest is ignored
    always_ff @(posedge clock) begin
        if (reset) begin
            ena_q <= '0;
            for (int i = 0; i < `EMS_SLOTS; i++) begin
                map_q[i] <= '0;
            end
        end
        else if (write_strobe) begin
            if (wdata == 8'hFF) begin
                ena_q[slot] <= 1'b0;
                map_q[slot] <= '1;
            end
            else if (~wdata[7]) begin
                ena_q[slot] <= 1'b1;
                map_q[slot] <= wdata[`EMS_MAP_W-1:0];
            end
        end
    end

    // Window segment high nibble
    always_comb begin
        case (ems_base_i)
            2'd0:    base_nibble = 4'hA;
            2'd1:    base_nibble = 4'hC;
            2'd2:    base_nibble = 4'hD;
            default: base_nibble = 4'hE;
        endcase
    end

    // Each slot covers a 16 KB page inside the 64 KB window
    always_comb begin
        for (int i = 0; i < `EMS_SLOTS; i++) begin
            window_hit_o[i] = ena_q[i] &&
                (bus_i.address[19:14] == {base_nibble, pc_periph_pkg::ems_slot_t'(i)});
        end
    end

    // Unmapped slots read back as all ones
    assign read_data_o = ena_q[slot] ? {1'b0, map_q[slot]} : 8'hFF;

endmodule

/* src/chipset_read_mux.sv */
//////////////////////////////////////////////////////////////////////
// Keycode two-stage synchronizer and prioritized chipset
// read data selection with the data-from-chipset flag
//////////////////////////////////////////////////////////////////////

module chipset_read_mux (
    input  logic                      clock,
    input  logic                      reset,
    input  pc_periph_pkg::bus_cycle_t bus_i,
    input  pc_periph_pkg::chip_sel_t  sel_i,
    input  pc_periph_pkg::data_t      ems_data_i,
    input  pc_periph_pkg::data_t      keycode_i,
    output pc_periph_pkg::data_t      data_bus_out_o,
    output logic                      data_from_chipset_o
);

    pc_periph_pkg::data_t keycode_meta_q;
    pc_periph_pkg::data_t keycode_sync_q;

    logic io_read;

    // Keycode comes from another clock domain
    always_ff @(posedge clock) begin
        if (reset) begin
            keycode_meta_q <= '0;
            keycode_sync_q <= '0;
        end
        else begin
            keycode_meta_q <= keycode_i;
            keycode_sync_q <= keycode_meta_q;
        end
    end

    assign io_read = ~bus_i.io_read_n;

    // EMS registers win over the scancode port
    always_comb begin
        if (io_read && sel_i.ems_sel) begin
            data_from_chipset_o = 1'b1;
            data_bus_out_o      = ems_data_i;
        end
        else if (io_read && sel_i.kbd_sel) begin
            data_from_chipset_o = 1'b1;
            data_bus_out_o      = keycode_sync_q;
        end
        else begin
            // Nobody answers, CPU side takes its own data
            data_from_chipset_o = 1'b0;
            data_bus_out_o      = 8'h00;
        end
    end

endmodule

/* src/pc_periph_top.sv */
//////////////////////////////////////////////////////////////////////
// Chipset glue logic top level with I/O decoder, EMS mapper
// and read data mux
//////////////////////////////////////////////////////////////////////

`include "pc_periph_defs.svh"

module pc_periph_top (
    input  logic                         clock,
    input  logic                         reset,
    // CPU bus
    input  pc_periph_pkg::bus_cycle_t    bus_i,
    // Configuration
    input  logic                         ems_enabled_i,
    input  pc_periph_pkg::ems_base_sel_t ems_base_i,
    // Keyboard, asynchronous
    input  pc_periph_pkg::data_t         keycode_i,
    // Off-chip selects
    output logic                         dma_sel_n_o,
    output logic                         dma_page_sel_n_o,
    output logic [`EMS_SLOTS-1:0]        ems_window_hit_o,
    // Read data back to the CPU
    output pc_periph_pkg::data_t         data_bus_out_o,
    output logic                         data_from_chipset_o
);

    pc_periph_pkg::chip_sel_t chip_sel;
    pc_periph_pkg::data_t     ems_read_data;

    io_decoder u_io_decoder (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .sel_o         (chip_sel)
    );

    // 8237 at group 0, DMA page registers at group 4
    assign dma_sel_n_o      = chip_sel.group_sel_n[0];
    assign dma_page_sel_n_o = chip_sel.group_sel_n[4];

    ems_mapper u_ems_mapper (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .sel_i        (chip_sel),
        .ems_base_i   (ems_base_i),
        .window_hit_o (ems_window_hit_o),
        .read_data_o  (ems_read_data)
    );

    chipset_read_mux u_read_mux (
        .clock               (clock),
        .reset               (reset),
        .bus_i               (bus_i),
        .sel_i               (chip_sel),
        .ems_data_i          (ems_read_data),
        .keycode_i           (keycode_i),
        .data_bus_out_o      (data_bus_out_o),
        .data_from_chipset_o (data_from_chipset_o)
    );

endmodule

/* test/tb_clock_gen.sv */
//////////////////////////////////////////////////////////////////////
// Testbench clock, period 20, and reset held for 5 cycles
//////////////////////////////////////////////////////////////////////

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #10 clock_o = ~clock_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clock_o);
        reset_o <= 1'b0;
    end

endmodule

/* test/pc_periph_sva.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the chipset top level, bound into
// pc_periph_top
//////////////////////////////////////////////////////////////////////

`include "pc_periph_defs.svh"

module pc_periph_sva (
    input logic                      clock,
    input logic                      reset,
    input pc_periph_pkg::bus_cycle_t bus_i,
    input logic [`IO_GROUPS-1:0]     group_sel_n_i,
    input logic [`EMS_SLOTS-1:0]     slot_ena_i,
    input logic [`EMS_SLOTS-1:0]     window_hit_i,
    input logic                      data_from_chipset_i
);

    // Chipset only answers I/O reads
    flag_needs_read: assert property (
        @(posedge clock) disable iff (reset)
        bus_i.io_read_n |-> !data_from_chipset_i
    ) else $error("data_from_chipset_o high while io_read_n is high");

    one_group_at_most: assert property (
        @(posedge clock) disable iff (reset)
        $countones(~group_sel_n_i) <= 1
    ) else $error("more than one I/O group select is low");

    // Unmapped slot must never claim its window
    hit_needs_enable: assert property (
        @(posedge clock) disable iff (reset)
        (window_hit_i & ~slot_ena_i) == '0
    ) else $error("EMS window hit on a disabled slot");

endmodule

bind pc_periph_top pc_periph_sva sva0 (
    .clock               (clock),
    .reset               (reset),
    .bus_i               (bus_i),
    .group_sel_n_i       (chip_sel.group_sel_n),
    .slot_ena_i          (u_ems_mapper.ena_q),
    .window_hit_i        (ems_window_hit_o),
    .data_from_chipset_i (data_from_chipset_o)
);

/* test/pc_periph_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the chipset glue logic: directed and LFSR stimulus,
// reference model, output comparison and per-test reporting
//////////////////////////////////////////////////////////////////////

`include "pc_periph_defs.svh"

module pc_periph_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_HOLD = 5;
    localparam int N_DECODE   = 160;
    localparam int N_ROUNDS   = 12;
    localparam int N_GATED    = 16;
    localparam int N_KEYS     = 8;

    // Cycles per test, the trailing 1 is the closing idle cycle
    localparam int RESET_CYCLES  = 4 + 4 * 5 + 1;
    localparam int DECODE_CYCLES = N_DECODE + 1;
    localparam int WRITE_CYCLES  = N_ROUNDS * 8 + 1;
    localparam int GATING_CYCLES = 2 + 4 * N_GATED + 4 + 1;
    localparam int WINDOW_CYCLES = 4 * (4 + 4 * 7) + 1;
    localparam int KBD_CYCLES    = N_KEYS * 6 + 1;
    localparam int TOTAL_CYCLES  = RESET_HOLD + 2 + RESET_CYCLES + DECODE_CYCLES +
                                   WRITE_CYCLES + GATING_CYCLES + WINDOW_CYCLES + KBD_CYCLES;
    localparam int MARGIN_CYCLES = 40;

    localparam logic [3:0] SLOT_PATTERNS [4] = '{4'h0, 4'hF, 4'h5, 4'hA};

    typedef struct packed {
        logic       dma_sel_n;
        logic       dma_page_sel_n;
        logic [3:0] window_hit;
        logic [7:0] data;
        logic       data_flag;
    } expect_t;

    logic clock;
    logic reset;

    pc_periph_pkg::bus_cycle_t     bus_drv;
    logic                          ems_enabled_drv;
    pc_periph_pkg::ems_base_sel_t  ems_base_drv;
    pc_periph_pkg::data_t          keycode_drv;

    logic                 dma_sel_n;
    logic                 dma_page_sel_n;
    logic [3:0]           window_hit;
    pc_periph_pkg::data_t data_out;
    logic                 data_flag;

    // Reference model state
    logic [3:0]      model_ena;
    logic [3:0][6:0] model_map;
    logic [7:0]      model_meta;
    logic [7:0]      model_sync;

    logic [31:0] lfsr_state = 32'hfa55_9bf3;
    int          check_count = 0;
    int          error_count = 0;
    int          checks_at_start = 0;
    int          errors_at_start = 0;

    tb_clock_gen clock_gen0 (
        .clock_o (clock),
        .reset_o (reset)
    );

    pc_periph_top dut0 (
        .clock               (clock),
        .reset               (reset),
        .bus_i               (bus_drv),
        .ems_enabled_i       (ems_enabled_drv),
        .ems_base_i          (ems_base_drv),
        .keycode_i           (keycode_drv),
        .dma_sel_n_o         (dma_sel_n),
        .dma_page_sel_n_o    (dma_page_sel_n),
        .ems_window_hit_o    (window_hit),
        .data_bus_out_o      (data_out),
        .data_from_chipset_o (data_flag)
    );

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < count; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    function automatic logic [3:0] segment_of(input logic [1:0] base_sel);
        case (base_sel)
            2'd0:    return 4'hA;
            2'd1:    return 4'hC;
            2'd2:    return 4'hD;
            default: return 4'hE;
        endcase
    endfunction

    function automatic logic ems_port_hit(input pc_periph_pkg::bus_cycle_t b,
                                          input logic ems_on);
        return ems_on && !b.address_enable_n &&
               b.address[15:0] >= `EMS_PORT_BASE &&
               b.address[15:0] < `EMS_PORT_BASE + `EMS_SLOTS;
    endfunction

    // Expected outputs for one bus cycle and the current model state
    function automatic expect_t predict_outputs(input pc_periph_pkg::bus_cycle_t b,
                                                input logic ems_on,
                                                input logic [1:0] base_sel,
                                                input logic [3:0] ena,
                                                input logic [3:0][6:0] maps,
                                                input logic [7:0] kbd);
        expect_t    e;
        logic       cpu_io;
        logic [1:0] slot;
        cpu_io = !b.address_enable_n;
        slot   = b.address[1:0];
        // Group 0 is ports 0x000..0x01F, group 4 is 0x080..0x09F
        e.dma_sel_n      = !(cpu_io && b.address[9:0] < 10'h020);
        e.dma_page_sel_n = !(cpu_io && b.address[9:0] >= 10'h080 && b.address[9:0] < 10'h0A0);
        for (int i = 0; i < 4; i++) begin
            e.window_hit[i] = ena[i] && b.address[19:16] == segment_of(base_sel) &&
                              b.address[15:14] == 2'(i);
        end
        if (!b.io_read_n && ems_port_hit(b, ems_on)) begin
            e.data_flag = 1'b1;
            e.data      = ena[slot] ? {1'b0, maps[slot]} : 8'hFF;
        end
        else if (!b.io_read_n && cpu_io && b.address[15:0] == `KBD_PORT) begin
            e.data_flag = 1'b1;
            e.data      = kbd;
        end
        else begin
            e.data_flag = 1'b0;
            e.data      = 8'h00;
        end
        return e;
    endfunction

    function automatic pc_periph_pkg::bus_cycle_t build_cycle(
        input pc_periph_pkg::addr_t a, input pc_periph_pkg::data_t d,
        input logic ior_n, input logic iow_n, input logic memr_n, input logic aen_n);
        pc_periph_pkg::bus_cycle_t b;
        b.address          = a;
        b.write_data       = d;
        b.io_read_n        = ior_n;
        b.io_write_n       = iow_n;
        b.memory_read_n    = memr_n;
        b.address_enable_n = aen_n;
        return b;
    endfunction

    function automatic pc_periph_pkg::bus_cycle_t idle_cycle();
        return build_cycle('0, '0, 1'b1, 1'b1, 1'b1, 1'b0);
    endfunction

    function automatic pc_periph_pkg::addr_t window_address(input logic [1:0] base_sel,
                                                            input logic [1:0] slot);
        return {segment_of(base_sel), slot, 14'(take_bits(14))};
    endfunction

    // Mix of unmap, ignored and mapping values
    function automatic pc_periph_pkg::data_t ems_test_byte();
        logic [1:0] kind;
        kind = 2'(take_bits(2));
        if (kind == 2'd0) begin
            return 8'hFF;
        end
        else if (kind == 2'd1) begin
            return 8'(take_bits(8)) | 8'h80;
        end
        return 8'(take_bits(7));
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic run_cycle(input pc_periph_pkg::bus_cycle_t b);
        @(posedge clock);
        bus_drv <= b;
    endtask

    task automatic set_config(input logic en, input logic [1:0] base_sel);
        @(posedge clock);
        bus_drv         <= idle_cycle();
        ems_enabled_drv <= en;
        ems_base_drv    <= base_sel;
    endtask

    task automatic end_test(input string name);
        run_cycle(idle_cycle());
        $display("Test %-8s %0d checks, %0d errors", name,
                 check_count - checks_at_start, error_count - errors_at_start);
        checks_at_start = check_count;
        errors_at_start = error_count;
    endtask

    task automatic test_reset();
        for (int s = 0; s < 4; s++) begin
            run_cycle(build_cycle(`EMS_PORT_BASE + s, '0, 1'b0, 1'b1, 1'b1, 1'b0));
        end
        for (int b = 0; b < 4; b++) begin
            set_config(1'b1, 2'(b));
            for (int w = 0; w < 4; w++) begin
                run_cycle(build_cycle(window_address(2'(b), 2'(w)), '0, 1'b1, 1'b1, 1'b0, 1'b0));
            end
        end
        end_test("reset");
    endtask

    task automatic test_decode();
        pc_periph_pkg::addr_t addr;
        for (int n = 0; n < N_DECODE; n++) begin
            addr = pc_periph_pkg::addr_t'(take_bits(20));
            // Keep most addresses inside the low 256 ports
            if (take_bits(2) != 0) begin
                addr[9:8] = 2'b00;
            end
            run_cycle(build_cycle(addr, '0, 1'(take_bits(1)), 1'b1, 1'b1, 1'(take_bits(1))));
        end
        end_test("decode");
    endtask

    task automatic test_ems_writes();
        logic [1:0] slot;
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int w = 0; w < 4; w++) begin
                slot = 2'(take_bits(2));
                run_cycle(build_cycle(`EMS_PORT_BASE + slot, ems_test_byte(),
                                      1'b1, 1'b0, 1'b1, 1'b0));
            end
            for (int s = 0; s < 4; s++) begin
                run_cycle(build_cycle(`EMS_PORT_BASE + s, '0, 1'b0, 1'b1, 1'b1, 1'b0));
            end
        end
        end_test("writes");
    endtask

    task automatic test_gating();
        pc_periph_pkg::addr_t addr;
        set_config(1'b0, 2'd0);
        for (int n = 0; n < 2 * N_GATED; n++) begin
            // Second half has EMS on but address enable high
            if (n == N_GATED) begin
                set_config(1'b1, 2'd0);
            end
            addr = `EMS_PORT_BASE + take_bits(2);
            run_cycle(build_cycle(addr, 8'(take_bits(7)), 1'b1, 1'b0, 1'b1, n >= N_GATED));
            run_cycle(build_cycle(addr, '0, 1'b0, 1'b1, 1'b1, n >= N_GATED));
        end
        for (int s = 0; s < 4; s++) begin
            run_cycle(build_cycle(`EMS_PORT_BASE + s, '0, 1'b0, 1'b1, 1'b1, 1'b0));
        end
        end_test("gating");
    endtask

    task automatic test_windows();
        pc_periph_pkg::data_t d;
        for (int p = 0; p < 4; p++) begin
            for (int s = 0; s < 4; s++) begin
                d = SLOT_PATTERNS[p][s] ? 8'(take_bits(7)) : 8'hFF;
                run_cycle(build_cycle(`EMS_PORT_BASE + s, d, 1'b1, 1'b0, 1'b1, 1'b0));
            end
            for (int b = 0; b < 4; b++) begin
                set_config(1'b1, 2'(b));
                for (int w = 0; w < 4; w++) begin
                    run_cycle(build_cycle(window_address(2'(b), 2'(w)), '0,
                                          1'b1, 1'b1, 1'b0, 1'b0));
                end
                repeat (2) begin
                    run_cycle(build_cycle(20'(take_bits(20)), '0, 1'b1, 1'b1, 1'b0, 1'b0));
                end
            end
        end
        end_test("windows");
    endtask

    task automatic test_scancode();
        pc_periph_pkg::addr_t other;
        for (int k = 0; k < N_KEYS; k++) begin
            @(posedge clock);
            bus_drv     <= idle_cycle();
            keycode_drv <= 8'(take_bits(8));
            repeat (3) begin
                run_cycle(idle_cycle());
            end
            run_cycle(build_cycle(`KBD_PORT, '0, 1'b0, 1'b1, 1'b1, 1'b0));
            // Bit 10 keeps it off the scancode and EMS ports
            other = 20'(take_bits(16)) | 20'h00400;
            run_cycle(build_cycle(other, '0, 1'b0, 1'b1, 1'b1, 1'b0));
        end
        end_test("scancode");
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clock) begin : compare_outputs
        expect_t    exp_out;
        logic [1:0] slot;
        if (reset !== 1'b0) begin
            model_ena  = '0;
            model_map  = '0;
            model_meta = '0;
            model_sync = '0;
        end
        else begin
            exp_out = predict_outputs(bus_drv, ems_enabled_drv, ems_base_drv,
                                      model_ena, model_map, model_sync);
            check_value("dma_sel_n_o", 8'(dma_sel_n), 8'(exp_out.dma_sel_n));
            check_value("dma_page_sel_n_o", 8'(dma_page_sel_n), 8'(exp_out.dma_page_sel_n));
            check_value("ems_window_hit_o", 8'(window_hit), 8'(exp_out.window_hit));
            check_value("data_bus_out_o", data_out, exp_out.data);
            check_value("data_from_chipset_o", 8'(data_flag), 8'(exp_out.data_flag));
            // Register write lands on the next rising edge
            if (ems_port_hit(bus_drv, ems_enabled_drv) && !bus_drv.io_write_n) begin
                slot = bus_drv.address[1:0];
                if (bus_drv.write_data == 8'hFF) begin
                    model_ena[slot] = 1'b0;
                    model_map[slot] = 7'h7F;
                end
                else if (bus_drv.write_data < 8'h80) begin
                    model_ena[slot] = 1'b1;
                    model_map[slot] = bus_drv.write_data[6:0];
                end
            end
            model_sync = model_meta;
            model_meta = keycode_drv;
        end
    end

    initial begin
        #(CLK_PERIOD * (TOTAL_CYCLES + MARGIN_CYCLES));
        $display("Run did not finish within %0d cycles", TOTAL_CYCLES + MARGIN_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        bus_drv         = idle_cycle();
        ems_enabled_drv = 1'b1;
        ems_base_drv    = 2'd0;
        keycode_drv     = 8'h00;
        while (reset !== 1'b0) begin
            @(posedge clock);
        end

        test_reset();
        test_decode();
        test_ems_writes();
        test_gating();
        test_windows();
        test_scancode();

        $display("Total %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end
        else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+src
src/pc_periph_pkg.sv
src/io_decoder.sv
src/ems_mapper.sv
src/chipset_read_mux.sv
src/pc_periph_top.sv
test/tb_clock_gen.sv
test/pc_periph_sva.sv
test/pc_periph_tb.sv

/* Bender.yml */
package:
  name: pc_periph

sources:
  - include_dirs:
      - src
    files:
      - src/pc_periph_pkg.sv
      - src/io_decoder.sv
      - src/ems_mapper.sv
      - src/chipset_read_mux.sv
      - src/pc_periph_top.sv
      - target: test
        files:
          - test/tb_clock_gen.sv
          - test/pc_periph_sva.sv
          - test/pc_periph_tb.sv
